//--- verilog/gpio_lite_macros.svh
//----------------------------------------------------------------------
// widths, register offsets and reset values for the gpio_lite block
//----------------------------------------------------------------------
`ifndef GPIO_LITE_MACROS_SVH
`define GPIO_LITE_MACROS_SVH

// sizes
`define GPIO_WIDTH  16            // pins per block
`define GPIO_ADDR_W 6             // register address bits
`define GPIO_DATA_W 32            // axi4-lite data bus

//----------------------------------------------------------------------
// register map, byte offsets
//----------------------------------------------------------------------
`define GPR_DIRECTION_MODE 6'h04  // 1 = input, 0 = output
`define GPR_OUTPUT_ENABLE  6'h08  // driver enable per pin
`define GPR_OUTPUT_VALUE   6'h0C  // level driven on pin_out
`define GPR_INPUT_VALUE    6'h10  // synchronised pin_in, read only
`define GPR_INT_STATUS     6'h20  // rising edge flags, clear on read

//----------------------------------------------------------------------
// reset values
//----------------------------------------------------------------------
// all pins come up as outputs with drivers off
`define GPRV_DIRECTION_MODE 16'h0000
`define GPRV_OUTPUT_ENABLE  16'h0000  // tristated
`define GPRV_OUTPUT_VALUE   16'h0000
`define GPRV_INPUT_VALUE    16'h0000
`define GPRV_INT_STATUS     16'h0000  // nothing pending

`endif

//--- verilog/gpio_lite_pkg.sv
//----------------------------------------------------------------------
// shared types for gpio_lite: pin vector, bus address and data,
// axi4-lite front end states
//----------------------------------------------------------------------
`include "gpio_lite_macros.svh"

package gpio_lite_pkg;

  // one bit per pin
  typedef logic [`GPIO_WIDTH-1:0]  pin_vec_t;

  // register byte address
  typedef logic [`GPIO_ADDR_W-1:0] reg_addr_t;

  // full bus word, upper half unused by the core
  typedef logic [`GPIO_DATA_W-1:0] bus_data_t;

  // front end FSM
  typedef enum logic [2:0]
  {
    st_idle,   // collecting aw / w halves or waiting for ar
    st_write,  // write strobe to core
    st_wresp,  // bvalid up until bready
    st_read,   // read strobe to core
    st_rresp   // rvalid up until rready
  } axil_state_t;

endpackage

//--- verilog/gpio_axil_slave.sv
//----------------------------------------------------------------------
// axi4-lite slave front end for gpio_lite
// captures address and data, one transaction in flight, issues
// single cycle read / write strobes to the register core
//----------------------------------------------------------------------
`timescale 1ns/1ps
`include "gpio_lite_macros.svh"

module gpio_axil_slave
  import gpio_lite_pkg::*;
(
  input  logic      pclk27,
  input  logic      n_reset27,     // async, active low

  // write address
  input  reg_addr_t awaddr,
  input  logic      awvalid,
  output logic      awready,

  // write data
  input  bus_data_t wdata,
  input  logic [3:0] wstrb,        // byte lanes not supported
  input  logic      wvalid,
  output logic      wready,

  // write response, always okay
  output logic      bvalid,
  input  logic      bready,

  // read address
  input  reg_addr_t araddr,
  input  logic      arvalid,
  output logic      arready,

  // read data
  output bus_data_t rdata,
  output logic      rvalid,
  input  logic      rready,

  // register core side
  output logic      reg_read,      // one cycle strobe
  output logic      reg_write,     // one cycle strobe
  output reg_addr_t reg_addr,
  output pin_vec_t  reg_wdata,
  input  pin_vec_t  reg_rdata      // valid the cycle after reg_read
);

  axil_state_t state;
  logic        ready_en;           // held off until first edge after reset
  logic        aw_held;            // write address captured
  logic        w_held;             // write data captured
  logic        rd_first;           // first cycle of st_rresp
  reg_addr_t   addr_q;             // shared by read and write
  pin_vec_t    wdata_q;
  pin_vec_t    rdata_q;            // read data kept for back-pressure

  logic        aw_fire;
  logic        w_fire;
  logic        ar_fire;
  logic        aw_have;
  logic        w_have;
  pin_vec_t    rdata_lo;

  //--------------------------------------------------------------------
  // handshakes
  //--------------------------------------------------------------------
  assign awready = ready_en & (state == st_idle) & ~aw_held;
  assign wready  = ready_en & (state == st_idle) & ~w_held;
  // a pending or arriving write half blocks the read, so writes win
  assign arready = ready_en & (state == st_idle) & ~aw_held & ~w_held
                   & ~awvalid & ~wvalid;

  assign aw_fire = awvalid & awready;
  assign w_fire  = wvalid & wready;
  assign ar_fire = arvalid & arready;

  assign aw_have = aw_held | aw_fire;  // address held or arriving now
  assign w_have  = w_held | w_fire;

  //--------------------------------------------------------------------
  // FSM
  //--------------------------------------------------------------------
  always_ff @(posedge pclk27 or negedge n_reset27)
  begin
    if (!n_reset27)
    begin
      state    <= st_idle;
      ready_en <= 1'b0;
      aw_held  <= 1'b0;
      w_held   <= 1'b0;
      rd_first <= 1'b0;
    end
    else
    begin
      ready_en <= 1'b1;
      rd_first <= (state == st_read);  // core answers one edge later
      case (state)
        st_idle:
        begin
          if (aw_have && w_have)
          begin
            state   <= st_write;       // both halves in
            aw_held <= 1'b0;
            w_held  <= 1'b0;
          end
          else
          begin
            aw_held <= aw_have;
            w_held  <= w_have;
            if (ar_fire)
              state <= st_read;
          end
        end
        st_write:
          state <= st_wresp;
        st_wresp:
          if (bready)
            state <= st_idle;
        st_read:
          state <= st_rresp;
        st_rresp:
          if (rready)
            state <= st_idle;
        default:
          state <= st_idle;
      endcase
    end
  end

  //--------------------------------------------------------------------
  // payload capture
  //--------------------------------------------------------------------
  always_ff @(posedge pclk27)
  begin
    if (aw_fire)
      addr_q <= awaddr;
    else if (ar_fire)
      addr_q <= araddr;
    if (w_fire)
      wdata_q <= wdata[`GPIO_WIDTH-1:0];  // upper half dropped
    if (rd_first)
      rdata_q <= reg_rdata;               // core zeroes it next cycle
  end

  // core strobes
  assign reg_write = (state == st_write);
  assign reg_read  = (state == st_read);
  assign reg_addr  = addr_q;
  assign reg_wdata = wdata_q;

  // responses
  assign bvalid   = (state == st_wresp);
  assign rvalid   = (state == st_rresp);
  assign rdata_lo = rd_first ? reg_rdata : rdata_q;
  assign rdata    = {{(`GPIO_DATA_W-`GPIO_WIDTH){1'b0}}, rdata_lo};  // zero extend

endmodule

//--- verilog/gpio_lite_subunit.sv
//----------------------------------------------------------------------
// gpio register core: register file, two flop input synchroniser,
// rising edge interrupt status and pin drive
//----------------------------------------------------------------------
`timescale 1ns/1ps
`include "gpio_lite_macros.svh"

module gpio_lite_subunit
  import gpio_lite_pkg::*;
(
  input  logic      pclk27,
  input  logic      n_reset27,      // async, active low

  // from bus front end
  input  logic      reg_read,       // one cycle read strobe
  input  logic      reg_write,      // one cycle write strobe
  input  reg_addr_t reg_addr,
  input  pin_vec_t  reg_wdata,
  output pin_vec_t  reg_rdata,      // zero unless answering a read

  // pins
  input  pin_vec_t  pin_in,         // asynchronous to pclk27
  input  pin_vec_t  test_tristate,  // dft, 1 forces driver off
  output pin_vec_t  pin_out,
  output pin_vec_t  pin_oe_n,       // active low enable
  output pin_vec_t  interrupt       // one status bit per pin
);

  //--------------------------------------------------------------------
  // registers
  //--------------------------------------------------------------------
  pin_vec_t direction_mode;         // 1 input, 0 output       rw
  pin_vec_t output_enable;          // driver on               rw
  pin_vec_t output_value;           // level to drive          rw
  pin_vec_t input_value;            // synchronised pin_in     r
  pin_vec_t int_status;             // edge flags              r, clear on read

  // synchroniser stages
  pin_vec_t sync_one;               // pin side flop
  pin_vec_t sync_two;               // second stage, safe to use

  pin_vec_t int_event;              // rising edge seen this cycle
  pin_vec_t int_trigger;            // rising edge on an input pin
  pin_vec_t status_clear;

  // address decodes
  logic     ad_direction_mode;
  logic     ad_output_enable;
  logic     ad_output_value;
  logic     ad_int_status;

  assign ad_direction_mode = (reg_addr == `GPR_DIRECTION_MODE);
  assign ad_output_enable  = (reg_addr == `GPR_OUTPUT_ENABLE);
  assign ad_output_value   = (reg_addr == `GPR_OUTPUT_VALUE);
  assign ad_int_status     = (reg_addr == `GPR_INT_STATUS);

  //--------------------------------------------------------------------
  // writable registers
  //--------------------------------------------------------------------
  always_ff @(posedge pclk27 or negedge n_reset27)
  begin
    if (!n_reset27)
    begin
      direction_mode <= `GPRV_DIRECTION_MODE;
      output_enable  <= `GPRV_OUTPUT_ENABLE;
      output_value   <= `GPRV_OUTPUT_VALUE;
    end
    else if (reg_write)
    begin
      // whole register replaced, no byte lanes
      if (ad_direction_mode)
        direction_mode <= reg_wdata;
      if (ad_output_enable)
        output_enable <= reg_wdata;
      if (ad_output_value)
        output_value <= reg_wdata;
    end
  end

  //--------------------------------------------------------------------
  // input synchroniser
  //--------------------------------------------------------------------
  // pin_in -> sync_one -> sync_two -> input_value, three edges
  always_ff @(posedge pclk27 or negedge n_reset27)
  begin
    if (!n_reset27)
    begin
      sync_one    <= '0;
      sync_two    <= '0;
      input_value <= `GPRV_INPUT_VALUE;
    end
    else
    begin
      sync_one    <= pin_in;
      sync_two    <= sync_one;
      input_value <= sync_two;
    end
  end

  //--------------------------------------------------------------------
  // interrupt status
  //--------------------------------------------------------------------
  // new level high and different from last stored value
  assign int_event    = (sync_two ^ input_value) & sync_two;
  assign int_trigger  = direction_mode & int_event;  // output pins ignored
  // any read of the status register wipes every bit
  assign status_clear = {`GPIO_WIDTH{reg_read & ad_int_status}};

  always_ff @(posedge pclk27 or negedge n_reset27)
  begin
    if (!n_reset27)
      int_status <= `GPRV_INT_STATUS;
    else
      int_status <= (int_status & ~status_clear)  // clear on read
                    | int_trigger;                // new edge wins
  end

  assign interrupt = int_status;

  //--------------------------------------------------------------------
  // read data
  //--------------------------------------------------------------------
  always_ff @(posedge pclk27 or negedge n_reset27)
  begin
    if (!n_reset27)
      reg_rdata <= '0;
    else if (reg_read)
    begin
      case (reg_addr)
        `GPR_DIRECTION_MODE: reg_rdata <= direction_mode;
        `GPR_OUTPUT_ENABLE:  reg_rdata <= output_enable;
        `GPR_OUTPUT_VALUE:   reg_rdata <= output_value;
        `GPR_INT_STATUS:     reg_rdata <= int_status;  // value before clear
        default:             reg_rdata <= input_value; // input reg and unmapped
      endcase
    end
    else
      reg_rdata <= '0;                                  // idle bus reads zero
  end

  //--------------------------------------------------------------------
  // pin drive
  //--------------------------------------------------------------------
  assign pin_out  = output_value;
  // driver on only for enabled output pins, dft can force it off
  assign pin_oe_n = ~(output_enable & ~direction_mode) | test_tristate;

endmodule

//--- verilog/gpio_lite_top.sv
//----------------------------------------------------------------------
// gpio_lite top: axi4-lite front end joined to the register core
//----------------------------------------------------------------------
`timescale 1ns/1ps

module gpio_lite_top
  import gpio_lite_pkg::*;
(
  input  logic       pclk27,
  input  logic       n_reset27,
  // axi4-lite
  input  reg_addr_t  awaddr,
  input  logic       awvalid,
  output logic       awready,
  input  bus_data_t  wdata,
  input  logic [3:0] wstrb,
  input  logic       wvalid,
  output logic       wready,
  output logic       bvalid,
  input  logic       bready,
  input  reg_addr_t  araddr,
  input  logic       arvalid,
  output logic       arready,
  output bus_data_t  rdata,
  output logic       rvalid,
  input  logic       rready,
  // pins
  input  pin_vec_t   pin_in,
  input  pin_vec_t   test_tristate,
  output pin_vec_t   pin_out,
  output pin_vec_t   pin_oe_n,
  output pin_vec_t   interrupt
);

  // front end to core
  logic      reg_read;
  logic      reg_write;
  reg_addr_t reg_addr;
  pin_vec_t  reg_wdata;
  pin_vec_t  reg_rdata;

  gpio_axil_slave u_axil_slave
  (
    .pclk27    (pclk27),
    .n_reset27 (n_reset27),
    .awaddr    (awaddr),
    .awvalid   (awvalid),
    .awready   (awready),
    .wdata     (wdata),
    .wstrb     (wstrb),
    .wvalid    (wvalid),
    .wready    (wready),
    .bvalid    (bvalid),
    .bready    (bready),
    .araddr    (araddr),
    .arvalid   (arvalid),
    .arready   (arready),
    .rdata     (rdata),
    .rvalid    (rvalid),
    .rready    (rready),
    .reg_read  (reg_read),
    .reg_write (reg_write),
    .reg_addr  (reg_addr),
    .reg_wdata (reg_wdata),
    .reg_rdata (reg_rdata)
  );

  gpio_lite_subunit u_subunit
  (
    .pclk27        (pclk27),
    .n_reset27     (n_reset27),
    .reg_read      (reg_read),
    .reg_write     (reg_write),
    .reg_addr      (reg_addr),
    .reg_wdata     (reg_wdata),
    .reg_rdata     (reg_rdata),
    .pin_in        (pin_in),
    .test_tristate (test_tristate),
    .pin_out       (pin_out),
    .pin_oe_n      (pin_oe_n),
    .interrupt     (interrupt)
  );

endmodule

//--- bench/gpio_axil_bfm.svh
//----------------------------------------------------------------------
// axi4-lite master tasks: write, read, response with back-pressure
// every wait bounded by wait_limit cycles
//----------------------------------------------------------------------
`ifndef GPIO_AXIL_BFM_SVH
`define GPIO_AXIL_BFM_SVH

// b or r channel, ready held low for hold cycles once valid is up
task automatic take_response(input bit is_read, input int hold, output bus_data_t data);
  int   cnt;
  logic vld;
  logic still;
  cnt = 0;
  @(negedge pclk27);                       // outputs settled mid cycle
  vld = is_read ? rvalid : bvalid;
  while (!vld && cnt < wait_limit)
  begin
    @(negedge pclk27);
    vld = is_read ? rvalid : bvalid;
    cnt++;
  end
  data = rdata;                            // first beat of read data
  if (!vld)
  begin
    $display("no %s response within %0d cycles", is_read ? "read" : "write", wait_limit);
    error_count++;
  end
  // slave must sit in its response state and take nothing new
  for (int i = 0; vld && i < hold; i++)
  begin
    step_cycle();
    @(negedge pclk27);
    still = is_read ? rvalid : bvalid;
    if (still !== 1'b1) report_mismatch(is_read ? "rvalid" : "bvalid", still, 1);
    if (is_read && rdata !== data) report_mismatch("rdata", rdata, data);
    if (arready !== 1'b0) report_mismatch("arready", arready, 0);
  end
  if (vld && hold > 0)
  begin
    step_cycle();
    if (is_read)
      rready = 1'b1;
    else
      bready = 1'b1;
    @(negedge pclk27);                     // transfer on next edge
  end
  step_cycle();
  bready = 1'b0;
  rready = 1'b0;
endtask

// full register write, both halves offered together
task automatic axil_write(input reg_addr_t addr, input bus_data_t data, input int hold);
  int        cnt;
  bit        aw_hit;
  bit        w_hit;
  bus_data_t unused;
  awaddr  = addr;
  awvalid = 1'b1;
  wdata   = data;
  wstrb   = 4'hF;                          // slave ignores lanes
  wvalid  = 1'b1;
  bready  = (hold == 0);
  cnt     = 0;
  while ((awvalid || wvalid) && cnt < wait_limit)
  begin
    @(negedge pclk27);
    aw_hit = awvalid & awready;
    w_hit  = wvalid & wready;
    step_cycle();
    if (aw_hit)
      awvalid = 1'b0;                      // taken on that edge
    if (w_hit)
      wvalid = 1'b0;
    cnt++;
  end
  if (awvalid || wvalid)
  begin
    $display("write handshake timed out at address %h", addr);
    error_count++;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    bready  = 1'b0;
  end
  else
    take_response(1'b0, hold, unused);
endtask

// register read, returns the zero-extended bus word
task automatic axil_read(input reg_addr_t addr, input int hold, output bus_data_t data);
  int cnt;
  bit hit;
  araddr  = addr;
  arvalid = 1'b1;
  rready  = (hold == 0);
  cnt     = 0;
  data    = '0;
  while (arvalid && cnt < wait_limit)
  begin
    @(negedge pclk27);
    hit = arready;                         // arvalid up, so edge transfers
    step_cycle();
    if (hit)
      arvalid = 1'b0;
    cnt++;
  end
  if (arvalid)
  begin
    $display("read handshake timed out at address %h", addr);
    error_count++;
    arvalid = 1'b0;
    rready  = 1'b0;
  end
  else
    take_response(1'b1, hold, data);
endtask

`endif

//--- bench/gpio_lite_tb.sv
//----------------------------------------------------------------------
// testbench for gpio_lite_top with clock, reset, lfsr data, a stimulus
// table built from a register model, and pin, input and interrupt checks
//----------------------------------------------------------------------
`timescale 1ns/1ps
`include "gpio_lite_macros.svh"

module gpio_lite_tb
  import gpio_lite_pkg::*;
();

  localparam int wait_limit = 40;          // cycles per bounded wait

  typedef enum logic {op_read, op_write} stim_op_t;
  typedef struct packed
  {
    stim_op_t  op;
    reg_addr_t addr;
    bus_data_t data;
    bus_data_t expect_val;                 // read entries only
    bus_data_t mask;
    pin_vec_t  exp_out;                    // pins after a write
    pin_vec_t  exp_oe_n;                   // with test_tristate low
  } stim_entry_t;

  logic        pclk27;
  logic        n_reset27;
  reg_addr_t   awaddr;
  logic        awvalid;
  logic        awready;
  bus_data_t   wdata;
  logic [3:0]  wstrb;
  logic        wvalid;
  logic        wready;
  logic        bvalid;
  logic        bready;
  reg_addr_t   araddr;
  logic        arvalid;
  logic        arready;
  bus_data_t   rdata;
  logic        rvalid;
  logic        rready;
  pin_vec_t    pin_in;
  pin_vec_t    test_tristate;
  pin_vec_t    pin_out;
  pin_vec_t    pin_oe_n;
  pin_vec_t    interrupt;

  stim_entry_t stim_q[$];
  logic [31:0] lfsr_state;
  pin_vec_t    m_dir;                      // register model
  pin_vec_t    m_oe;
  pin_vec_t    m_out;
  pin_vec_t    m_in;
  int          error_count;
  int          test_count;
  int          test_fail;

  gpio_lite_top uut (.*);

  always #2 pclk27 = ~pclk27;              // 4 ns period

  //--------------------------------------------------------------------
  // helpers
  //--------------------------------------------------------------------
  task automatic step_cycle();
    @(posedge pclk27);
    #1;                                    // drive point
  endtask

  task automatic report_mismatch(input string name, input bus_data_t got, input bus_data_t exp);
    $display("Mismatch %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
    error_count++;
  endtask

  // galois lfsr stepped once per bit
  function automatic logic step_lfsr();
    logic lsb;
    lsb = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (lsb)
      lfsr_state = lfsr_state ^ 32'h80200003;
    return lsb;
  endfunction

  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
      v = {v[30:0], step_lfsr()};
    return v;
  endfunction

  // register map rules where unmapped reads give the input value
  function automatic bus_data_t model_read(input reg_addr_t addr);
    case (addr)
      `GPR_DIRECTION_MODE: return {16'h0000, m_dir};
      `GPR_OUTPUT_ENABLE:  return {16'h0000, m_oe};
      `GPR_OUTPUT_VALUE:   return {16'h0000, m_out};
      default:             return {16'h0000, m_in};
    endcase
  endfunction

  task automatic add_write(input reg_addr_t addr, input bus_data_t data);
    stim_entry_t e;
    case (addr)
      `GPR_DIRECTION_MODE: m_dir = data[15:0];  // upper half dropped
      `GPR_OUTPUT_ENABLE:  m_oe  = data[15:0];
      `GPR_OUTPUT_VALUE:   m_out = data[15:0];
      default: ;
    endcase
    e = '{op_write, addr, data, '0, '0, m_out, ~(m_oe & ~m_dir)};
    stim_q.push_back(e);
  endtask

  task automatic add_read(input reg_addr_t addr, input bus_data_t exp);
    stim_entry_t e;
    e = '{op_read, addr, '0, exp, 32'hFFFF_FFFF, '0, '0};  // upper half must be zero
    stim_q.push_back(e);
  endtask

  `include "gpio_axil_bfm.svh"

  // pins checked with dft off and then with random test_tristate
  task automatic check_pins(input pin_vec_t exp_out, input pin_vec_t exp_oe_n);
    pin_vec_t tt;
    pin_vec_t oe_tt;
    @(negedge pclk27);
    if (pin_out !== exp_out) report_mismatch("pin_out", pin_out, exp_out);
    if (pin_oe_n !== exp_oe_n) report_mismatch("pin_oe_n", pin_oe_n, exp_oe_n);
    tt    = pin_vec_t'(random_bits(`GPIO_WIDTH));
    oe_tt = exp_oe_n | tt;
    step_cycle();
    test_tristate = tt;
    @(negedge pclk27);
    if (pin_oe_n !== oe_tt) report_mismatch("pin_oe_n", pin_oe_n, oe_tt);
    step_cycle();
    test_tristate = '0;
  endtask

  task automatic run_stimulus();
    stim_entry_t e;
    bus_data_t   rd;
    while (stim_q.size() > 0)
    begin
      e = stim_q.pop_front();
      if (e.op == op_write)
      begin
        axil_write(e.addr, e.data, 0);
        check_pins(e.exp_out, e.exp_oe_n);
      end
      else
      begin
        axil_read(e.addr, 0, rd);
        if ((rd & e.mask) !== (e.expect_val & e.mask)) report_mismatch("rdata", rd, e.expect_val);
      end
    end
  endtask

  // reads the input register until it shows value or gives up
  task automatic poll_input(input pin_vec_t value);
    bus_data_t rd;
    int        cnt;
    cnt = 0;
    axil_read(`GPR_INPUT_VALUE, 0, rd);
    while (rd !== {16'h0000, value} && cnt < wait_limit)
    begin
      axil_read(`GPR_INPUT_VALUE, 0, rd);
      cnt++;
    end
    if (rd !== {16'h0000, value}) report_mismatch("input_value", rd, {16'h0000, value});
  endtask

  task automatic end_test(input string name, input int errors_before);
    test_count++;
    if (error_count == errors_before)
      $display("test %0d %s: ok", test_count, name);
    else
    begin
      test_fail++;
      $display("test %0d %s: failed, %0d errors", test_count, name, error_count - errors_before);
    end
  endtask

  //--------------------------------------------------------------------
  // main sequence
  //--------------------------------------------------------------------
  initial
  begin
    bus_data_t rd;
    pin_vec_t  rise;
    pin_vec_t  exp_int;
    int        start;
    int        cnt;
    pclk27        = 1'b0;
    n_reset27     = 1'b0;
    awaddr        = '0;
    awvalid       = 1'b0;
    wdata         = '0;
    wstrb         = 4'h0;
    wvalid        = 1'b0;
    bready        = 1'b0;
    araddr        = '0;
    arvalid       = 1'b0;
    rready        = 1'b0;
    pin_in        = '0;
    test_tristate = '0;
    lfsr_state    = 32'h21403f36;
    m_dir         = `GPRV_DIRECTION_MODE;
    m_oe          = `GPRV_OUTPUT_ENABLE;
    m_out         = `GPRV_OUTPUT_VALUE;
    m_in          = `GPRV_INPUT_VALUE;
    error_count   = 0;
    test_count    = 0;
    test_fail     = 0;

    // reset state while n_reset27 is low for 4 cycles
    start = error_count;
    repeat (3) @(posedge pclk27);
    @(negedge pclk27);
    if (pin_oe_n !== 16'hFFFF) report_mismatch("pin_oe_n", pin_oe_n, 16'hFFFF);
    if (interrupt !== `GPRV_INT_STATUS) report_mismatch("interrupt", interrupt, 0);
    if (bvalid !== 1'b0) report_mismatch("bvalid", bvalid, 0);
    if (rvalid !== 1'b0) report_mismatch("rvalid", rvalid, 0);
    if (awready !== 1'b0) report_mismatch("awready", awready, 0);
    if (wready !== 1'b0) report_mismatch("wready", wready, 0);
    if (arready !== 1'b0) report_mismatch("arready", arready, 0);
    step_cycle();
    n_reset27 = 1'b1;
    add_read(`GPR_DIRECTION_MODE, `GPRV_DIRECTION_MODE);
    add_read(`GPR_OUTPUT_ENABLE, `GPRV_OUTPUT_ENABLE);
    add_read(`GPR_OUTPUT_VALUE, `GPRV_OUTPUT_VALUE);
    add_read(`GPR_INPUT_VALUE, `GPRV_INPUT_VALUE);
    add_read(`GPR_INT_STATUS, `GPRV_INT_STATUS);
    run_stimulus();
    end_test("reset values", start);

    // readback with random upper halves plus unmapped addresses
    start = error_count;
    for (int r = 0; r < 2; r++)
    begin
      add_write(`GPR_DIRECTION_MODE, random_bits(32));
      add_write(`GPR_OUTPUT_ENABLE, random_bits(32));
      add_write(`GPR_OUTPUT_VALUE, random_bits(32));
      add_read(`GPR_DIRECTION_MODE, model_read(`GPR_DIRECTION_MODE));
      add_read(`GPR_OUTPUT_ENABLE, model_read(`GPR_OUTPUT_ENABLE));
      add_read(`GPR_OUTPUT_VALUE, model_read(`GPR_OUTPUT_VALUE));
      add_read(6'h00, model_read(6'h00));
      add_read(6'h3C, model_read(6'h3C));
    end
    run_stimulus();
    end_test("register readback", start);

    // pin drive checked after every write
    start = error_count;
    for (int r = 0; r < 3; r++)
    begin
      add_write(`GPR_OUTPUT_ENABLE, random_bits(32));
      add_write(`GPR_DIRECTION_MODE, random_bits(32));
      add_write(`GPR_OUTPUT_VALUE, random_bits(32));
    end
    run_stimulus();
    end_test("pin drive", start);

    // input synchroniser path
    start = error_count;
    m_in   = pin_vec_t'(random_bits(`GPIO_WIDTH));
    pin_in = m_in;                         // held from here on
    poll_input(m_in);
    add_read(6'h14, model_read(6'h14));
    run_stimulus();
    end_test("input path", start);

    //------------------------------------------------------------------
    // interrupts with half the pins as inputs
    //------------------------------------------------------------------
    start = error_count;
    add_write(`GPR_DIRECTION_MODE, 32'h0000_A5A5);
    run_stimulus();
    pin_in = '0;
    m_in   = '0;
    poll_input(m_in);
    axil_read(`GPR_INT_STATUS, 0, rd);     // drop flags left by input test
    axil_read(`GPR_INT_STATUS, 0, rd);
    if (rd !== 32'h0) report_mismatch("rdata", rd, 0);
    rise    = pin_vec_t'(random_bits(`GPIO_WIDTH)) | 16'h0001;  // pin 0 is an input
    exp_int = rise & m_dir;
    pin_in  = rise;
    cnt     = 0;
    @(negedge pclk27);
    while (interrupt === '0 && cnt < wait_limit)
    begin
      @(negedge pclk27);
      cnt++;
    end
    if (interrupt === '0)
    begin
      $display("interrupt never rose after rising pin edges");
      error_count++;
    end
    if (interrupt !== exp_int) report_mismatch("interrupt", interrupt, exp_int);
    step_cycle();
    axil_read(`GPR_INT_STATUS, 0, rd);
    if (rd !== {16'h0000, exp_int}) report_mismatch("rdata", rd, {16'h0000, exp_int});
    @(negedge pclk27);
    if (interrupt !== '0) report_mismatch("interrupt", interrupt, 0);
    step_cycle();
    pin_in = '0;                           // falling edges set nothing
    poll_input('0);
    @(negedge pclk27);
    if (interrupt !== '0) report_mismatch("interrupt", interrupt, 0);
    step_cycle();
    end_test("interrupts", start);

    // back-pressure on b and r
    start = error_count;
    rd = random_bits(32);
    axil_write(`GPR_OUTPUT_VALUE, rd, 5);
    m_out = rd[15:0];
    axil_read(`GPR_OUTPUT_VALUE, 6, rd);
    if (rd !== {16'h0000, m_out}) report_mismatch("rdata", rd, {16'h0000, m_out});
    @(negedge pclk27);
    if (pin_out !== m_out) report_mismatch("pin_out", pin_out, m_out);
    step_cycle();
    end_test("back-pressure", start);

    $display("tests %0d, failed %0d, errors %0d", test_count, test_fail, error_count);
    if (error_count == 0)
      $display(">>> PASS");
    else
      $display(">>> FAIL");
    $finish;
  end

endmodule

//--- gpio_lite.f
+incdir+verilog
+incdir+bench
verilog/gpio_lite_pkg.sv
verilog/gpio_axil_slave.sv
verilog/gpio_lite_subunit.sv
verilog/gpio_lite_top.sv
bench/gpio_lite_tb.sv

//--- Bender.yml
package:
  name: gpio_lite

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/gpio_lite_pkg.sv
      - verilog/gpio_axil_slave.sv
      - verilog/gpio_lite_subunit.sv
      - verilog/gpio_lite_top.sv
  - target: test
    include_dirs:
      - verilog
      - bench
    files:
      - bench/gpio_lite_tb.sv
